/* rv_core_top.f */
+incdir+common
common/rv_isa_pkg.sv
common/rv_pipe_pkg.sv
hdl/rv_fetch.sv
decode/rv_regfile.sv
decode/rv_decoder.sv
hdl/rv_execute.sv
hdl/rv_lsu.sv
hdl/rv_core_top.sv
test/rv_core_asserts.sv
test/rv_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f rv_core_top.f --top-module rv_core_tb -o rv_core_sim

./obj_dir/rv_core_sim | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
    exit 0
fi
exit 1

/* test/rv_core_tb.sv */
// RV64 core testbench
module rv_core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    logic    clk;
    logic    reset;
    addr_t   imem_addr;
    inst_t   imem_data;
    wb_m2s_t wb_m2s;
    wb_s2m_t wb_s2m;
    logic    retire_valid;
    retire_t retire;
    logic    halt;
    logic    illegal;

    inst_t   rom [256];
    xlen_t   dmem [128];    // seen by the bus model
    xlen_t   iss_mem [128]; // seen by the reference model
    xlen_t   iss_regs [32];
    addr_t   iss_pc;
    logic    iss_halted;
    integer  seed;
    int      prog_len;
    int      cycles;
    int      limit;
    int      retired;
    int      delay_left;
    logic    delay_armed;

    rv_core_top rv_core_top_i (
        .clk_i          (clk),
        .reset_i        (reset),
        .imem_addr_o    (imem_addr),
        .imem_data_i    (imem_data),
        .wb_o           (wb_m2s),
        .wb_i           (wb_s2m),
        .retire_valid_o (retire_valid),
        .retire_o       (retire),
        .halt_o         (halt),
        .illegal_o      (illegal)
    );

    bind rv_core_top rv_core_asserts u_core_asserts (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .wb_m2s_i       (wb_o),
        .wb_s2m_i       (wb_i),
        .retire_valid_i (retire_valid_o),
        .halt_i         (halt_o)
    );

    assign imem_data = rom[imem_addr[9:2]]; // combinational ROM port

    function automatic int rnd(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic reg_idx_t rnd_reg();
        return reg_idx_t'(rnd(8)); // small set so results feed later ops
    endfunction

    function automatic xlen_t fill_word(int idx);
        return {32'h5a00_0000 ^ idx, ~idx};
    endfunction

    function automatic inst_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                    reg_idx_t rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic inst_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3, reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic inst_t enc_s(logic [11:0] imm, reg_idx_t rs2);
        return {imm[11:5], rs2, 5'd0, 3'b011, imm[4:0], 7'h23}; // sd, base x0
    endfunction

    function automatic inst_t enc_b(logic [12:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic inst_t enc_j(logic [20:0] imm, reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    task automatic emit(inst_t word);
        rom[prog_len] = word;
        prog_len++;
    endtask

    task automatic emit_rtype();
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        rd  = rnd_reg();
        rs1 = rnd_reg();
        rs2 = rnd_reg();
        case (rnd(5))
            0: emit(enc_r(7'h00, rs2, rs1, 3'b000, rd)); // add
            1: emit(enc_r(7'h20, rs2, rs1, 3'b000, rd)); // sub
            2: emit(enc_r(7'h00, rs2, rs1, 3'b111, rd)); // and
            3: emit(enc_r(7'h00, rs2, rs1, 3'b110, rd)); // or
            default: emit(enc_r(7'h00, rs2, rs1, 3'b100, rd)); // xor
        endcase
    endtask

    task automatic build_program();
        logic [11:0] off;
        for (int i = 0; i < 256; i++) begin
            rom[i] = 32'h0010_0073;
        end
        prog_len = 0;
        for (int g = 0; g < 6; g++) begin
            emit(enc_i(12'($random(seed)), rnd_reg(), 3'b000, rnd_reg(), 7'h13)); // addi
            emit({20'($random(seed)), rnd_reg(), 7'h37}); // lui
            emit_rtype();
            off = 12'(rnd(16) * 8);
            emit(enc_s(off, rnd_reg()));
            emit(enc_i(off, 5'd0, 3'b011, rnd_reg(), 7'h03)); // ld same address
            emit(enc_i(12'(rnd(16) * 8), 5'd0, 3'b011, rnd_reg(), 7'h03));
            emit(enc_b(13'd8, rnd_reg(), rnd_reg(), 3'b000)); // beq over next
            emit_rtype();
            emit(enc_b(13'd8, rnd_reg(), rnd_reg(), 3'b001)); // bne over next
            emit_rtype();
            emit(enc_j(21'd8, rnd_reg()));
            emit_rtype(); // always skipped
            emit((g % 2 == 0) ? 32'h0000_7013 : 32'hffff_ffff); // not in the subset
            emit(enc_i(12'($random(seed)), rnd_reg(), 3'b000, 5'd0, 7'h13)); // to x0
            emit(enc_r(7'h00, 5'd0, 5'd0, 3'b000, rnd_reg())); // reads x0
        end
        emit(32'h0010_0073); // ebreak
    endtask

    // one step of the ISA model, returns what the core should retire
    function automatic retire_t iss_step();
        inst_t    in;
        xlen_t    a;
        xlen_t    b;
        xlen_t    imm_i;
        addr_t    npc;
        retire_t  r;
        in    = rom[iss_pc[9:2]];
        a     = iss_regs[in[19:15]];
        b     = iss_regs[in[24:20]];
        imm_i = {{52{in[31]}}, in[31:20]};
        npc   = iss_pc + 64'd4;
        r     = '0;
        r.pc  = iss_pc;
        r.rd  = in[11:7];
        r.we  = 1'b1;
        case (in[6:0])
            7'h33: begin
                case ({in[31:25], in[14:12]})
                    10'b0000000_000: r.value = a + b;
                    10'b0100000_000: r.value = a - b;
                    10'b0000000_111: r.value = a & b;
                    10'b0000000_110: r.value = a | b;
                    10'b0000000_100: r.value = a ^ b;
                    default:         r.illegal = 1'b1;
                endcase
            end
            7'h13: begin
                if (in[14:12] == 3'b000) r.value = a + imm_i;
                else r.illegal = 1'b1;
            end
            7'h37: r.value = {{32{in[31]}}, in[31:12], 12'b0};
            7'h03: begin
                if (in[14:12] == 3'b011) r.value = iss_mem[7'((a + imm_i) >> 3)];
                else r.illegal = 1'b1;
            end
            7'h23: begin
                r.we = 1'b0;
                if (in[14:12] == 3'b011) begin
                    iss_mem[7'((a + {{52{in[31]}}, in[31:25], in[11:7]}) >> 3)] = b;
                end else begin
                    r.illegal = 1'b1;
                end
            end
            7'h63: begin
                r.we = 1'b0;
                if (in[14:13] != 2'b00) r.illegal = 1'b1;
                else if ((a == b) != in[12]) begin
                    npc = iss_pc + {{51{in[31]}}, in[31], in[7], in[30:25], in[11:8], 1'b0};
                end
            end
            7'h6f: begin
                r.value = iss_pc + 64'd4; // link
                npc = iss_pc + {{43{in[31]}}, in[31], in[19:12], in[20], in[30:21], 1'b0};
            end
            default: begin
                r.we = 1'b0;
                if (in == 32'h0010_0073) iss_halted = 1'b1;
                else r.illegal = 1'b1;
            end
        endcase
        if (r.illegal) r.we = 1'b0;
        if (r.we && r.rd != 5'd0) iss_regs[r.rd] = r.value;
        iss_pc = npc;
        return r;
    endfunction

    // bus request the model expects for the ld or sd it is about to step
    function automatic wb_m2s_t expected_request();
        inst_t   in;
        xlen_t   off;
        wb_m2s_t req;
        in = rom[iss_pc[9:2]];
        if (in[6:0] == 7'h23) begin
            off = {{52{in[31]}}, in[31:25], in[11:7]};
        end else begin
            off = {{52{in[31]}}, in[31:20]};
        end
        req     = '0;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we  = (in[6:0] == 7'h23);
        req.adr = iss_regs[in[19:15]] + off;
        req.dat = iss_regs[in[24:20]];
        req.sel = '1; // whole doubleword
        return req;
    endfunction

    function automatic string test_name(inst_t in);
        case (in[6:0])
            7'h03, 7'h23: return "load_store";
            7'h63, 7'h6f: return "branch_jump";
            7'h33, 7'h13, 7'h37: return (in[11:7] == 5'd0) ? "x0_write" : "alu";
            default: return (in == 32'h0010_0073) ? "halt" : "illegal";
        endcase
    endfunction

    task automatic report_fail();
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_retire(string name, retire_t exp, retire_t act);
        if (act.we !== exp.we || act.illegal !== exp.illegal
                || (exp.we && (act.rd !== exp.rd || act.value !== exp.value))) begin
            $display("Mismatch %s: expected %h actual %h", name, exp, act);
            report_fail();
        end
    endtask

    task automatic check_pc(string name, addr_t exp, addr_t act);
        if (act !== exp) begin
            $display("Mismatch %s pc: expected %h actual %h", name, exp, act);
            report_fail();
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("Mismatch %s flag: expected %b actual %b", name, exp, act);
            report_fail();
        end
    endtask

    task automatic check_request(string name, wb_m2s_t exp, wb_m2s_t act);
        if (act.we !== exp.we || act.adr !== exp.adr || act.sel !== exp.sel
                || (exp.we && act.dat !== exp.dat)) begin
            $display("Mismatch %s bus: expected %h actual %h", name, exp, act);
            report_fail();
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // wishbone slave with random ack delay
    always @(negedge clk) begin
        if (reset) begin
            wb_s2m.ack  <= 1'b0;
            delay_armed = 1'b0;
        end else if (wb_s2m.ack) begin
            wb_s2m.ack <= 1'b0;
        end else if (wb_m2s.cyc && wb_m2s.stb) begin
            if (!delay_armed) begin
                check_request(test_name(rom[iss_pc[9:2]]), expected_request(), wb_m2s);
                delay_left  = rnd(7);
                delay_armed = 1'b1;
            end
            if (delay_left == 0) begin
                delay_armed = 1'b0;
                wb_s2m.ack <= 1'b1;
                if (wb_m2s.we) dmem[wb_m2s.adr[9:3]] = wb_m2s.dat;
                else wb_s2m.dat <= dmem[wb_m2s.adr[9:3]];
            end else begin
                delay_left--;
            end
        end
    end

    // compare each retire with the model
    always @(negedge clk) begin
        string   name;
        retire_t exp;
        if (!reset && retire_valid) begin
            name = test_name(rom[iss_pc[9:2]]);
            exp  = iss_step();
            check_pc(name, exp.pc, retire.pc);
            check_retire(name, exp, retire);
            check_flag(name, exp.illegal, illegal);
            check_flag(name, iss_halted, halt);
            retired++;
        end
    end

    always @(posedge clk) begin
        if (!reset) cycles++;
        if (cycles > limit) begin
            $display("Timeout: core stopped retiring after %0d cycles", cycles);
            report_fail();
        end
    end

    initial begin
        seed        = 32'h46c;
        reset       = 1'b1;
        wb_s2m      = '0;
        cycles      = 0;
        retired     = 0;
        delay_left  = 0;
        delay_armed = 1'b0;
        iss_pc      = 64'h0;
        iss_halted  = 1'b0;
        for (int i = 0; i < 32; i++) iss_regs[i] = '0;
        for (int i = 0; i < 128; i++) begin
            dmem[i]    = fill_word(i);
            iss_mem[i] = fill_word(i);
        end
        build_program();
        limit = prog_len * (4 + 7) + 20;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        wait (halt);
        repeat (6) @(negedge clk);
        if (iss_halted && retired > 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("core halted before the model reached its ebreak");
            report_fail();
        end
    end

endmodule

/* test/rv_core_asserts.sv */
// core bus and retire checks
module rv_core_asserts (
    input logic                 clk_i,
    input logic                 reset_i,
    input rv_pipe_pkg::wb_m2s_t wb_m2s_i,
    input rv_pipe_pkg::wb_s2m_t wb_s2m_i,
    input logic                 retire_valid_i,
    input logic                 halt_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // request held until the slave answers
    stb_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        (wb_m2s_i.stb && !wb_s2m_i.ack) |=> (wb_m2s_i.stb && $stable(wb_m2s_i.adr)
            && $stable(wb_m2s_i.dat) && $stable(wb_m2s_i.we) && $stable(wb_m2s_i.sel)))
        else $error("wishbone request changed before ack");

    cyc_drop: assert property (@(posedge clk_i) disable iff (reset_i)
        (wb_m2s_i.cyc && wb_s2m_i.ack) |=> !wb_m2s_i.cyc)
        else $error("cyc still high after ack");

    halt_sticky: assert property (@(posedge clk_i) disable iff (reset_i)
        halt_i |=> halt_i)
        else $error("halt dropped before reset");

    no_retire_after_halt: assert property (@(posedge clk_i) disable iff (reset_i)
        halt_i |=> !retire_valid_i)
        else $error("instruction retired after halt");

endmodule

/* hdl/rv_core_top.sv */
// RV64I core top level
module rv_core_top (
    input  logic                 clk_i,
    input  logic                 reset_i,
    output rv_isa_pkg::addr_t    imem_addr_o,
    input  rv_isa_pkg::inst_t    imem_data_i,
    output rv_pipe_pkg::wb_m2s_t wb_o,
    input  rv_pipe_pkg::wb_s2m_t wb_i,
    output logic                 retire_valid_o,
    output rv_pipe_pkg::retire_t retire_o,
    output logic                 halt_o,
    output logic                 illegal_o
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    fetch_reg_t  fetch_q;
    decode_reg_t decode_q;
    exec_reg_t   exec_q;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    xlen_t       rs1_data;
    xlen_t       rs2_data;

    rv_fetch u_fetch (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .retire_valid_i (retire_valid_o),
        .halt_i         (halt_o),
        .next_pc_i      (exec_q.next_pc), // held until the next decode
        .imem_addr_o    (imem_addr_o),
        .imem_data_i    (imem_data_i),
        .fetch_o        (fetch_q)
    );

    rv_decoder u_decoder (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .fetch_i    (fetch_q),
        .rs1_o      (rs1),
        .rs2_o      (rs2),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .decode_o   (decode_q)
    );

    rv_regfile u_regfile (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .rs1_i          (rs1),
        .rs2_i          (rs2),
        .rs1_data_o     (rs1_data),
        .rs2_data_o     (rs2_data),
        .retire_valid_i (retire_valid_o),
        .retire_i       (retire_o)
    );

    rv_execute u_execute (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .decode_i (decode_q),
        .exec_o   (exec_q)
    );

    rv_lsu u_lsu (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .exec_i         (exec_q),
        .wb_o           (wb_o),
        .wb_i           (wb_i),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o),
        .halt_o         (halt_o),
        .illegal_o      (illegal_o)
    );

endmodule

/* hdl/rv_lsu.sv */
// memory access and retire stage
module rv_lsu (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  rv_pipe_pkg::exec_reg_t exec_i,
    output rv_pipe_pkg::wb_m2s_t   wb_o,
    input  rv_pipe_pkg::wb_s2m_t   wb_i,
    output logic                   retire_valid_o,
    output rv_pipe_pkg::retire_t   retire_o,
    output logic                   halt_o,
    output logic                   illegal_o
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    typedef enum logic {
        IDLE,
        BUS
    } lsu_state_e;

    lsu_state_e state_q;
    logic       is_mem;
    logic       start;
    logic       done;
    retire_t    retire_d;

    assign is_mem = (exec_i.iclass == LOAD) || (exec_i.iclass == STORE);
    assign start  = (state_q == IDLE) && exec_i.valid && is_mem;
    assign done   = ((state_q == IDLE) && exec_i.valid && !is_mem)
                 || ((state_q == BUS) && wb_i.ack);

    // exec register holds its payload while the bus is busy
    always_comb begin
        retire_d.pc      = exec_i.pc;
        retire_d.rd      = exec_i.rd;
        retire_d.value   = (exec_i.iclass == LOAD) ? wb_i.dat : exec_i.result;
        retire_d.we      = exec_i.rd_we;
        retire_d.illegal = (exec_i.iclass == ILLEGAL);
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q        <= IDLE;
            wb_o.cyc       <= 1'b0;
            wb_o.stb       <= 1'b0;
            retire_valid_o <= 1'b0;
            halt_o         <= 1'b0;
            illegal_o      <= 1'b0;
        end else begin
            retire_valid_o <= done;
            illegal_o      <= done && retire_d.illegal;
            if (done && (exec_i.iclass == EBREAK)) begin
                halt_o <= 1'b1; // sticky until reset
            end
            if (start) begin
                state_q  <= BUS;
                wb_o.cyc <= 1'b1;
                wb_o.stb <= 1'b1;
            end else if ((state_q == BUS) && wb_i.ack) begin
                state_q  <= IDLE;
                wb_o.cyc <= 1'b0; // drop right after ack
                wb_o.stb <= 1'b0;
            end
        end
        if (start) begin
            wb_o.we  <= (exec_i.iclass == STORE);
            wb_o.adr <= exec_i.result;
            wb_o.dat <= exec_i.store_data;
            wb_o.sel <= '1; // full doubleword only
        end
        if (done) begin
            retire_o <= retire_d;
        end
    end

endmodule

/* hdl/rv_execute.sv */
// execute stage
module rv_execute (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  rv_pipe_pkg::decode_reg_t decode_i,
    output rv_pipe_pkg::exec_reg_t   exec_o
);
    import rv_isa_pkg::*;

    xlen_t op_b;
    xlen_t alu_res;
    addr_t pc_plus4;
    addr_t target;
    logic  equal;
    logic  taken;

    assign op_b     = decode_i.use_imm ? decode_i.imm : decode_i.rs2_val;
    assign pc_plus4 = decode_i.pc + addr_t'(4);
    assign target   = decode_i.pc + decode_i.imm; // branch and jal target
    assign equal    = (decode_i.rs1_val == decode_i.rs2_val);

    always_comb begin
        case (decode_i.alu_op)
            ADD:     alu_res = decode_i.rs1_val + op_b; // also ld/sd address
            SUB:     alu_res = decode_i.rs1_val - op_b;
            AND:     alu_res = decode_i.rs1_val & op_b;
            OR:      alu_res = decode_i.rs1_val | op_b;
            XOR:     alu_res = decode_i.rs1_val ^ op_b;
            default: alu_res = op_b;
        endcase
    end

    always_comb begin
        taken = (decode_i.iclass == JUMP)
             || ((decode_i.iclass == BRANCH_EQ) && equal)
             || ((decode_i.iclass == BRANCH_NE) && !equal);
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            exec_o.valid <= 1'b0;
        end else begin
            exec_o.valid <= decode_i.valid;
        end
        if (decode_i.valid) begin
            exec_o.pc         <= decode_i.pc;
            exec_o.iclass     <= decode_i.iclass;
            exec_o.result     <= (decode_i.iclass == JUMP) ? pc_plus4 : alu_res; // link
            exec_o.store_data <= decode_i.rs2_val;
            exec_o.rd         <= decode_i.rd;
            exec_o.rd_we      <= decode_i.rd_we;
            exec_o.next_pc    <= taken ? target : pc_plus4;
        end
    end

endmodule

/* decode/rv_decoder.sv */
// instruction decode stage
`include "rvcore_defs.svh"

module rv_decoder (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  rv_pipe_pkg::fetch_reg_t  fetch_i,
    output rv_isa_pkg::reg_idx_t     rs1_o,
    output rv_isa_pkg::reg_idx_t     rs2_o,
    input  rv_isa_pkg::xlen_t        rs1_data_i,
    input  rv_isa_pkg::xlen_t        rs2_data_i,
    output rv_pipe_pkg::decode_reg_t decode_o
);
    import rv_isa_pkg::*;

    inst_t       inst;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    xlen_t       imm_i;
    xlen_t       imm_s;
    xlen_t       imm_b;
    xlen_t       imm_u;
    xlen_t       imm_j;
    inst_class_e iclass;
    alu_op_e     alu_op;
    xlen_t       imm;
    logic        use_imm;
    logic        rd_we;
    logic        op_ok;

    assign inst   = fetch_i.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rs1_o  = inst[19:15]; // regfile read is combinational
    assign rs2_o  = inst[24:20];

    assign imm_i = {{(`RV_XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_s = {{(`RV_XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{(`RV_XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {{(`RV_XLEN-32){inst[31]}}, inst[31:12], 12'b0};
    assign imm_j = {{(`RV_XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        iclass  = ILLEGAL; // anything not matched below
        alu_op  = ADD;
        imm     = imm_i;
        use_imm = 1'b0;
        rd_we   = 1'b0;
        op_ok   = 1'b0;
        case (opcode)
            7'b0110011: begin // register-register
                op_ok = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: alu_op = ADD;
                    10'b0100000_000: alu_op = SUB;
                    10'b0000000_111: alu_op = AND;
                    10'b0000000_110: alu_op = OR;
                    10'b0000000_100: alu_op = XOR;
                    default:         op_ok  = 1'b0;
                endcase
                if (op_ok) begin
                    iclass = ALU;
                    rd_we  = 1'b1;
                end
            end
            7'b0010011: begin // addi only
                use_imm = 1'b1;
                if (funct3 == 3'b000) begin
                    iclass = ALU;
                    rd_we  = 1'b1;
                end
            end
            7'b0110111: begin // lui
                iclass  = ALU;
                alu_op  = PASS_B;
                imm     = imm_u;
                use_imm = 1'b1;
                rd_we   = 1'b1;
            end
            7'b0000011: begin // ld
                use_imm = 1'b1;
                if (funct3 == 3'b011) begin
                    iclass = LOAD;
                    rd_we  = 1'b1;
                end
            end
            7'b0100011: begin // sd
                imm     = imm_s;
                use_imm = 1'b1;
                if (funct3 == 3'b011) begin
                    iclass = STORE;
                end
            end
            7'b1100011: begin
                imm = imm_b;
                if (funct3 == 3'b000) begin
                    iclass = BRANCH_EQ;
                end else if (funct3 == 3'b001) begin
                    iclass = BRANCH_NE;
                end
            end
            7'b1101111: begin // jal
                iclass = JUMP;
                imm    = imm_j;
                rd_we  = 1'b1;
            end
            7'b1110011: begin
                if (inst == 32'h0010_0073) begin
                    iclass = EBREAK;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            decode_o.valid <= 1'b0;
        end else begin
            decode_o.valid <= fetch_i.valid;
        end
        if (fetch_i.valid) begin
            decode_o.pc      <= fetch_i.pc;
            decode_o.iclass  <= iclass;
            decode_o.alu_op  <= alu_op;
            decode_o.rs1_val <= rs1_data_i;
            decode_o.rs2_val <= rs2_data_i;
            decode_o.imm     <= imm;
            decode_o.use_imm <= use_imm;
            decode_o.rd      <= inst[11:7];
            decode_o.rd_we   <= rd_we;
        end
    end

endmodule

/* decode/rv_regfile.sv */
// integer register file
`include "rvcore_defs.svh"

module rv_regfile (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  rv_isa_pkg::reg_idx_t rs1_i,
    input  rv_isa_pkg::reg_idx_t rs2_i,
    output rv_isa_pkg::xlen_t    rs1_data_o,
    output rv_isa_pkg::xlen_t    rs2_data_o,
    input  logic                 retire_valid_i,
    input  rv_pipe_pkg::retire_t retire_i
);
    import rv_isa_pkg::*;

    xlen_t regs_q [`RV_REG_COUNT];

    // x0 is never written, so it keeps its reset value of zero
    assign rs1_data_o = regs_q[rs1_i];
    assign rs2_data_o = regs_q[rs2_i];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs_q[i] <= '0;
            end
        end else if (retire_valid_i && retire_i.we && (retire_i.rd != '0)) begin
            regs_q[retire_i.rd] <= retire_i.value;
        end
    end

endmodule

/* hdl/rv_fetch.sv */
// instruction fetch stage
`include "rvcore_defs.svh"

module rv_fetch (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic                    retire_valid_i,
    input  logic                    halt_i,
    input  rv_isa_pkg::addr_t       next_pc_i,
    output rv_isa_pkg::addr_t       imem_addr_o,
    input  rv_isa_pkg::inst_t       imem_data_i,
    output rv_pipe_pkg::fetch_reg_t fetch_o
);
    import rv_isa_pkg::*;

    addr_t pc_q;
    logic  issue_ok_q; // set out of reset, cleared by the first capture
    logic  resume;
    logic  issue;

    assign resume      = retire_valid_i && !halt_i; // previous instruction done
    assign issue       = issue_ok_q || resume;
    assign imem_addr_o = resume ? next_pc_i : pc_q; // redirect lands this cycle

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_q          <= `RV_RESET_PC;
            issue_ok_q    <= 1'b1;
            fetch_o.valid <= 1'b0;
        end else begin
            fetch_o.valid <= issue;
            if (resume) begin
                pc_q <= next_pc_i;
            end
            if (issue) begin
                issue_ok_q <= 1'b0; // wait for retire before the next one
            end
        end
        if (issue) begin
            fetch_o.pc   <= imem_addr_o;
            fetch_o.inst <= imem_data_i;
        end
    end

endmodule

/* common/rv_pipe_pkg.sv */
// pipeline and bus records
`include "rvcore_defs.svh"

package rv_pipe_pkg;

    import rv_isa_pkg::*;

    typedef struct packed {
        logic  valid;
        addr_t pc;
        inst_t inst;
    } fetch_reg_t;

    typedef struct packed {
        logic        valid;
        addr_t       pc;
        inst_class_e iclass;
        alu_op_e     alu_op;
        xlen_t       rs1_val;
        xlen_t       rs2_val;
        xlen_t       imm;
        logic        use_imm; // operand b from imm instead of rs2
        reg_idx_t    rd;
        logic        rd_we;
    } decode_reg_t;

    typedef struct packed {
        logic        valid;
        addr_t       pc;
        inst_class_e iclass;
        xlen_t       result;     // alu value, link value or bus address
        xlen_t       store_data;
        reg_idx_t    rd;
        logic        rd_we;
        addr_t       next_pc;
    } exec_reg_t;

    typedef struct packed {
        addr_t    pc;
        reg_idx_t rd;
        xlen_t    value;
        logic     we;
        logic     illegal;
    } retire_t;

    // wishbone classic, master to slave
    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        addr_t                  adr;
        xlen_t                  dat;
        logic [`RV_XLEN/8-1:0]  sel;
    } wb_m2s_t;

    typedef struct packed {
        xlen_t dat;
        logic  ack;
    } wb_s2m_t;

endpackage

/* common/rv_isa_pkg.sv */
// RV64I subset types
`include "rvcore_defs.svh"

package rv_isa_pkg;

    typedef logic [`RV_XLEN-1:0]   xlen_t;    // register and data value
    typedef logic [`RV_XLEN-1:0]   addr_t;    // byte address
    typedef logic [`RV_ILEN-1:0]   inst_t;    // raw instruction word
    typedef logic [`RV_REG_AW-1:0] reg_idx_t; // x0..x31

    // ALU function picked by the decoder
    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        PASS_B   // lui, operand b straight through
    } alu_op_e;

    // what the later stages have to do with an instruction
    typedef enum logic [2:0] {
        ALU,
        LOAD,
        STORE,
        BRANCH_EQ,
        BRANCH_NE,
        JUMP,
        EBREAK,
        ILLEGAL
    } inst_class_e;

endpackage

/* common/rvcore_defs.svh */
// RV64 core parameters
`ifndef RVCORE_DEFS_SVH
`define RVCORE_DEFS_SVH

// data path and address width
`define RV_XLEN 64

// instruction word width
`define RV_ILEN 32

// register file geometry
`define RV_REG_AW 5
`define RV_REG_COUNT 32

// first fetch address out of reset
`define RV_RESET_PC 64'h0

`endif
